/* hw/fifo_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_apb_regs #(
   parameter int AFULL_RESET  = 12,     // afull_lvl after reset
   parameter int AEMPTY_RESET = 4       // aempty_lvl after reset
) (
   input  wire logic               pos_clk,
   input  wire logic               aresetn,
   // APB slave port
   input  wire fifo_pkg::apb_req_t apb_req_i,
   output fifo_pkg::apb_rsp_t      apb_rsp_o,
   // From the controller
   input  wire fifo_pkg::level_t   level_i,
   input  wire fifo_pkg::status_t  status_i,
   input  wire fifo_pkg::err_t     err_i,
   // To the controller
   output fifo_pkg::thresh_t       thresh_o
);

   // ----------------------------------------------------------
   // Access decode
   // ----------------------------------------------------------
   logic              access;           // Access phase of a transfer
   logic              wr_en;
   logic              hit_thresh;
   logic              hit_status;
   logic              hit_err;
   logic              unmapped;
   logic              clr_ovf;          // Write-one-to-clear strobes
   logic              clr_udf;
   fifo_pkg::thresh_t thresh_q;
   logic              ovf_sticky_q;
   logic              udf_sticky_q;
   logic [31:0]       prdata;

   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;

   assign hit_thresh = (apb_req_i.paddr == fifo_pkg::REG_THRESH);
   assign hit_status = (apb_req_i.paddr == fifo_pkg::REG_STATUS);
   assign hit_err    = (apb_req_i.paddr == fifo_pkg::REG_ERR);
   assign unmapped   = ~(hit_thresh | hit_status | hit_err);

   assign clr_ovf = wr_en & hit_err & apb_req_i.pwdata[0];
   assign clr_udf = wr_en & hit_err & apb_req_i.pwdata[1];

   // ----------------------------------------------------------
   // Threshold register
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         thresh_q.afull_lvl  <= fifo_pkg::level_t'(AFULL_RESET);
         thresh_q.aempty_lvl <= fifo_pkg::level_t'(AEMPTY_RESET);
      end else if (wr_en && hit_thresh) begin
         thresh_q.afull_lvl  <= apb_req_i.pwdata[4:0];     // afull level
         thresh_q.aempty_lvl <= apb_req_i.pwdata[12:8];    // aempty level
      end
   end

   assign thresh_o = thresh_q;

   // ----------------------------------------------------------
   // Sticky error bits
   // ----------------------------------------------------------
   // Set wins over clear in the same cycle
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         ovf_sticky_q <= 1'b0;
         udf_sticky_q <= 1'b0;
      end else begin
         ovf_sticky_q <= err_i.overflow  | (ovf_sticky_q & ~clr_ovf);
         udf_sticky_q <= err_i.underflow | (udf_sticky_q & ~clr_udf);
      end
   end

   // ----------------------------------------------------------
   // Read mux and response
   // ----------------------------------------------------------
   always_comb begin
      prdata = '0;
      if (access && !apb_req_i.pwrite) begin
         if (hit_thresh) begin
            prdata[4:0]  = thresh_q.afull_lvl;
            prdata[12:8] = thresh_q.aempty_lvl;
         end
         if (hit_status) begin
            prdata[4:0]  = level_i;
            prdata[11:8] = status_i;       // full, afull, empty, aempty
         end
         if (hit_err) begin
            prdata[0] = ovf_sticky_q;
            prdata[1] = udf_sticky_q;
         end
      end
   end

   assign apb_rsp_o.prdata  = prdata;
   assign apb_rsp_o.pready  = 1'b1;       // Zero wait states
   // Bad offset, or a write to the read-only status word
   assign apb_rsp_o.pslverr = access & (unmapped | (apb_req_i.pwrite & hit_status));

endmodule

`default_nettype wire

/* hw/fifo_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_ctrl (
   input  wire logic              pos_clk,
   input  wire logic              aresetn,
   // Write side
   input  wire logic              push_i,
   input  wire fifo_pkg::data_t   wdata_i,
   // Read side
   input  wire logic              pop_i,
   // Almost flag levels from the register block
   input  wire fifo_pkg::thresh_t thresh_i,
   // Memory ports
   output fifo_pkg::mem_wr_t      mem_wr_o,
   output fifo_pkg::mem_rd_t      mem_rd_o,
   // Handshake pulses
   output logic                   wack_o,
   output logic                   rvalid_o,
   // Occupancy and flags
   output fifo_pkg::level_t       level_o,
   output fifo_pkg::status_t      status_o,
   output fifo_pkg::err_t         err_o
);

   // ----------------------------------------------------------
   // Internal state
   // ----------------------------------------------------------
   fifo_pkg::level_t  level_q;          // Current occupancy
   fifo_pkg::level_t  level_nxt;        // Occupancy after this cycle
   fifo_pkg::addr_t   waddr_q;          // Next slot to write
   fifo_pkg::addr_t   raddr_q;          // Next slot to read
   fifo_pkg::status_t status_q;         // Registered flags
   fifo_pkg::err_t    err_q;            // Registered error pulses
   logic              wack_q;
   logic              rvalid_q;
   logic              wr_ok;            // Push accepted this cycle
   logic              rd_ok;            // Pop accepted this cycle

   // ----------------------------------------------------------
   // Accept logic
   // ----------------------------------------------------------
   // Only the registered flags gate requests, no stall path
   assign wr_ok = push_i & ~status_q.full;
   assign rd_ok = pop_i  & ~status_q.empty;

   // Memory ports run straight off the accept terms
   assign mem_wr_o.we   = wr_ok;
   assign mem_wr_o.addr = waddr_q;
   assign mem_wr_o.data = wdata_i;
   assign mem_rd_o.re   = rd_ok;
   assign mem_rd_o.addr = raddr_q;

   // ----------------------------------------------------------
   // Level counter
   // ----------------------------------------------------------
   always_comb begin
      case ({wr_ok, rd_ok})
         2'b10:   level_nxt = level_q + fifo_pkg::level_t'(1);   // Write only
         2'b01:   level_nxt = level_q - fifo_pkg::level_t'(1);   // Read only
         default: level_nxt = level_q;      // Both or neither, level holds
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q <= '0;
      end else begin
         level_q <= level_nxt;
      end
   end

   // ----------------------------------------------------------
   // Address counters, wrap at DEPTH
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_q <= '0;
      end else if (wr_ok) begin
         if (waddr_q == fifo_pkg::addr_t'(fifo_pkg::DEPTH - 1)) begin
            waddr_q <= '0;
         end else begin
            waddr_q <= waddr_q + fifo_pkg::addr_t'(1);
         end
      end
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_q <= '0;
      end else if (rd_ok) begin
         if (raddr_q == fifo_pkg::addr_t'(fifo_pkg::DEPTH - 1)) begin
            raddr_q <= '0;
         end else begin
            raddr_q <= raddr_q + fifo_pkg::addr_t'(1);
         end
      end
   end

   // ----------------------------------------------------------
   // Status flags
   // ----------------------------------------------------------
   // Updated every cycle so a new threshold shows up
   // even while the level stands still
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         status_q.full   <= 1'b0;
         status_q.afull  <= 1'b0;
         status_q.empty  <= 1'b1;       // Starts out empty
         status_q.aempty <= 1'b1;
      end else begin
         status_q.full   <= (level_nxt == fifo_pkg::level_t'(fifo_pkg::DEPTH));
         status_q.afull  <= (level_nxt >= thresh_i.afull_lvl);
         status_q.empty  <= (level_nxt == '0);
         status_q.aempty <= (level_nxt <= thresh_i.aempty_lvl);
      end
   end

   // ----------------------------------------------------------
   // Handshake and error pulses
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q   <= 1'b0;
         rvalid_q <= 1'b0;
         err_q    <= '0;
      end else begin
         wack_q          <= wr_ok;                 // Word landed in memory
         rvalid_q        <= rd_ok;                 // Lines up with RAM output reg
         err_q.overflow  <= push_i & status_q.full;
         err_q.underflow <= pop_i  & status_q.empty;
      end
   end

   // Outputs
   assign wack_o   = wack_q;
   assign rvalid_o = rvalid_q;
   assign level_o  = level_q;
   assign status_o = status_q;
   assign err_o    = err_q;

endmodule

`default_nettype wire

/* hw/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

   // ----------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------
   localparam int DATA_W = 16;            // Payload width
   localparam int ADDR_W = 4;             // Memory address width
   localparam int DEPTH  = 16;            // Entries, equals 2**ADDR_W
   localparam int LVL_W  = ADDR_W + 1;    // Holds 0 up to DEPTH
   localparam int APB_AW = 8;             // APB byte address width

   // ----------------------------------------------------------
   // APB register map, byte offsets
   // ----------------------------------------------------------
   localparam logic [APB_AW-1:0] REG_THRESH = 'h00;   // Almost flag levels, rw
   localparam logic [APB_AW-1:0] REG_STATUS = 'h04;   // Level and flags, ro
   localparam logic [APB_AW-1:0] REG_ERR    = 'h08;   // Sticky errors, w1c

   // ----------------------------------------------------------
   // Scalar types
   // ----------------------------------------------------------
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [LVL_W-1:0]  level_t;

   // Thresholds for the almost flags
   typedef struct packed {
      level_t afull_lvl;                  // afull when level >= this
      level_t aempty_lvl;                 // aempty when level <= this
   } thresh_t;

   // Registered FIFO flags
   typedef struct packed {
      logic full;
      logic afull;
      logic empty;
      logic aempty;
   } status_t;

   // One-cycle error pulses
   typedef struct packed {
      logic overflow;                     // Push refused, FIFO full
      logic underflow;                    // Pop refused, FIFO empty
   } err_t;

   // Memory write port
   typedef struct packed {
      logic  we;
      addr_t addr;
      data_t data;
   } mem_wr_t;

   // Memory read port
   typedef struct packed {
      logic  re;
      addr_t addr;
   } mem_rd_t;

   // APB master to slave
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [31:0]       pwdata;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

/* hw/fifo_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_ram (
   input  wire logic             pos_clk,
   input  wire fifo_pkg::mem_wr_t mem_wr_i,    // From controller write side
   input  wire fifo_pkg::mem_rd_t mem_rd_i,    // From controller read side
   output fifo_pkg::data_t        rdata_o      // Valid the cycle after re
);

   // ----------------------------------------------------------
   // Storage array
   // ----------------------------------------------------------
   fifo_pkg::data_t mem [fifo_pkg::DEPTH];     // Payload only, no reset
   fifo_pkg::data_t rdata_q;                   // Read port register

   // Write port
   always_ff @(posedge pos_clk) begin
      if (mem_wr_i.we) begin
         mem[mem_wr_i.addr] <= mem_wr_i.data;
      end
   end

   // Read port, registered
   // Same-address read and write never meet here
   // since the FIFO is then either empty or full
   always_ff @(posedge pos_clk) begin
      if (mem_rd_i.re) begin
         rdata_q <= mem[mem_rd_i.addr];     // Holds last word otherwise
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/fifo_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_top #(
   parameter int AFULL_RESET  = 12,     // Reset value of afull_lvl
   parameter int AEMPTY_RESET = 4       // Reset value of aempty_lvl
) (
   input  wire logic               pos_clk,
   input  wire logic               aresetn,
   // Write side
   input  wire logic               push_i,
   input  wire fifo_pkg::data_t    wdata_i,
   output logic                    wack_o,
   // Read side
   input  wire logic               pop_i,
   output fifo_pkg::data_t         rdata_o,
   output logic                    rvalid_o,
   // Flags and error pulses
   output fifo_pkg::status_t       status_o,
   output fifo_pkg::err_t          err_o,
   // Register access
   input  wire fifo_pkg::apb_req_t apb_req_i,
   output fifo_pkg::apb_rsp_t      apb_rsp_o
);

   // ----------------------------------------------------------
   // Interconnect
   // ----------------------------------------------------------
   fifo_pkg::mem_wr_t mem_wr;           // Controller to RAM write port
   fifo_pkg::mem_rd_t mem_rd;           // Controller to RAM read port
   fifo_pkg::thresh_t thresh;           // Register block to controller
   fifo_pkg::level_t  level;            // Controller to register block

   // Counters, flags and handshakes
   fifo_ctrl u_ctrl (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .push_i   (push_i),
      .wdata_i  (wdata_i),
      .pop_i    (pop_i),
      .thresh_i (thresh),
      .mem_wr_o (mem_wr),
      .mem_rd_o (mem_rd),
      .wack_o   (wack_o),
      .rvalid_o (rvalid_o),
      .level_o  (level),
      .status_o (status_o),
      .err_o    (err_o)
   );

   // Payload storage
   fifo_ram u_ram (
      .pos_clk  (pos_clk),
      .mem_wr_i (mem_wr),
      .mem_rd_i (mem_rd),
      .rdata_o  (rdata_o)
   );

   // APB register block
   fifo_apb_regs #(
      .AFULL_RESET  (AFULL_RESET),
      .AEMPTY_RESET (AEMPTY_RESET)
   ) u_regs (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .level_i   (level),
      .status_i  (status_o),
      .err_i     (err_o),
      .thresh_o  (thresh)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the FIFO testbench with Verilator, run it, and judge the result from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module fifo_tb -f vlog.f -o fifo_sim > build.log 2>&1 &&
   ./obj_dir/fifo_sim > sim.log 2>&1

if [ -f sim.log ]; then
   cat sim.log
else
   cat build.log
fi

grep -q "ALL TESTS PASSED" sim.log 2>/dev/null &&
   echo "Simulation result: pass" ||
   { echo "Simulation result: fail"; exit 1; }

exit 0

/* sim/fifo_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_tb;

   localparam int AFULL_INIT     = 12;          // Threshold reset values for uut
   localparam int AEMPTY_INIT    = 4;
   localparam int TIMEOUT_CYCLES = 2000;        // About four times the test length

   logic                pos_clk = 1'b0;
   logic                aresetn;
   logic                push;
   logic                pop;
   fifo_pkg::data_t     wdata;
   fifo_pkg::data_t     rdata;
   logic                wack;
   logic                rvalid;
   fifo_pkg::status_t   status;
   fifo_pkg::err_t      err;
   fifo_pkg::apb_req_t  apb_req;
   fifo_pkg::apb_rsp_t  apb_rsp;

   fifo_pkg::data_t     model_q[$];             // Scoreboard with the oldest word first
   int                  thr_afull  = AFULL_INIT;
   int                  thr_aempty = AEMPTY_INIT;
   logic [31:0]         rng_state  = 32'h9c74;
   int unsigned         cycle_cnt  = 0;

   fifo_top #(
      .AFULL_RESET  (AFULL_INIT),
      .AEMPTY_RESET (AEMPTY_INIT)
   ) uut (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .push_i    (push),
      .wdata_i   (wdata),
      .wack_o    (wack),
      .pop_i     (pop),
      .rdata_o   (rdata),
      .rvalid_o  (rvalid),
      .status_o  (status),
      .err_o     (err),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp)
   );

   always #20 pos_clk = ~pos_clk;               // 40 ns period

   // ----------------------------------------------------------
   // Failure reporting and compare tasks
   // ----------------------------------------------------------
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_data(input string name, input fifo_pkg::data_t exp,
                             input fifo_pkg::data_t act);
      if (act !== exp)
         stop_with_failure($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                     $time, name, exp, act));
   endtask

   task automatic check_status(input string name, input fifo_pkg::status_t exp,
                               input fifo_pkg::status_t act);
      if (act !== exp)                          // Bits are full, afull, empty, aempty
         stop_with_failure($sformatf("[FAIL] t=%0t %s expected %b actual %b",
                                     $time, name, exp, act));
   endtask

   task automatic check_err(input string name, input fifo_pkg::err_t exp,
                            input fifo_pkg::err_t act);
      if (act !== exp)                          // Bits are overflow, underflow
         stop_with_failure($sformatf("[FAIL] t=%0t %s expected %b actual %b",
                                     $time, name, exp, act));
   endtask

   task automatic check_level(input string name, input fifo_pkg::level_t exp,
                              input fifo_pkg::level_t act);
      if (act !== exp)
         stop_with_failure($sformatf("[FAIL] t=%0t %s expected %0d actual %0d",
                                     $time, name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_with_failure($sformatf("[FAIL] t=%0t %s expected %b actual %b",
                                     $time, name, exp, act));
   endtask

   // ----------------------------------------------------------
   // Models and stimulus helpers
   // ----------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic fifo_pkg::data_t next_word();
      rng_state = xorshift32(rng_state);
      return rng_state[fifo_pkg::DATA_W-1:0];   // Low half as payload
   endfunction

   // Expected flags for the scoreboard level
   function automatic fifo_pkg::status_t expected_status();
      fifo_pkg::status_t s;
      int                lvl;
      lvl      = model_q.size();
      s.full   = (lvl == fifo_pkg::DEPTH);
      s.afull  = (lvl >= thr_afull);
      s.empty  = (lvl == 0);
      s.aempty = (lvl <= thr_aempty);
      return s;
   endfunction

   // APB write with a setup and an access phase
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic slverr);
      @(posedge pos_clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b1;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= data;
      @(posedge pos_clk);
      apb_req.penable <= 1'b1;                  // Access phase
      @(negedge pos_clk);
      check_bit("pready", 1'b1, apb_rsp.pready);
      slverr = apb_rsp.pslverr;
      @(posedge pos_clk);                       // Register captures here
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic slverr);
      @(posedge pos_clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b0;
      apb_req.paddr   <= addr;
      @(posedge pos_clk);
      apb_req.penable <= 1'b1;
      @(negedge pos_clk);                       // prdata settles mid access phase
      check_bit("pready", 1'b1, apb_rsp.pready);
      data   = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(posedge pos_clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   // Level and flags through REG_STATUS against the scoreboard
   task automatic check_level_reg();
      logic [31:0] rd;
      logic        slverr;
      apb_read(fifo_pkg::REG_STATUS, rd, slverr);
      check_bit("pslverr REG_STATUS", 1'b0, slverr);
      check_level("REG_STATUS level", fifo_pkg::level_t'(model_q.size()), rd[4:0]);
      check_status("REG_STATUS flags", expected_status(), rd[11:8]);
   endtask

   task automatic push_word(input fifo_pkg::data_t d);
      @(posedge pos_clk);
      push  <= 1'b1;
      wdata <= d;
      @(posedge pos_clk);                       // Sampled by the DUT here
      push  <= 1'b0;
      @(negedge pos_clk);
      check_bit("wack_o", 1'b1, wack);
      model_q.push_back(d);
      check_status("status_o", expected_status(), status);
   endtask

   task automatic pop_word();
      fifo_pkg::data_t exp;
      @(posedge pos_clk);
      pop <= 1'b1;
      @(posedge pos_clk);
      pop <= 1'b0;
      @(negedge pos_clk);
      check_bit("rvalid_o", 1'b1, rvalid);
      exp = model_q.pop_front();
      check_data("rdata_o", exp, rdata);
      check_status("status_o", expected_status(), status);
   endtask

   // Refused push or pop followed by the sticky bit and its clear
   task automatic refused_request(input logic is_push);
      fifo_pkg::err_t  exp_err;
      fifo_pkg::err_t  sticky;
      fifo_pkg::data_t d;
      logic [31:0]     rd;
      logic            slverr;
      exp_err.overflow  = is_push;
      exp_err.underflow = ~is_push;
      d = next_word();
      @(posedge pos_clk);
      push  <= is_push;
      pop   <= ~is_push;
      wdata <= d;
      @(posedge pos_clk);
      push  <= 1'b0;
      pop   <= 1'b0;
      @(negedge pos_clk);
      check_err("err_o", exp_err, err);         // One-cycle pulse
      check_bit("wack_o", 1'b0, wack);
      check_bit("rvalid_o", 1'b0, rvalid);
      check_status("status_o", expected_status(), status);
      check_level_reg();                        // Level unchanged
      apb_read(fifo_pkg::REG_ERR, rd, slverr);
      sticky.overflow  = rd[0];
      sticky.underflow = rd[1];
      check_err("REG_ERR sticky", exp_err, sticky);
      apb_write(fifo_pkg::REG_ERR, is_push ? 32'h1 : 32'h2, slverr);   // Write one to clear
      check_bit("pslverr REG_ERR", 1'b0, slverr);
      apb_read(fifo_pkg::REG_ERR, rd, slverr);
      check_data("REG_ERR after clear", '0, rd[15:0]);
   endtask

   // ----------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------
   task automatic test_reset();
      logic [31:0] rd;
      logic        slverr;
      check_status("status_o", expected_status(), status);   // empty and aempty only
      check_err("err_o", '0, err);
      check_bit("wack_o", 1'b0, wack);
      check_bit("rvalid_o", 1'b0, rvalid);
      apb_read(fifo_pkg::REG_THRESH, rd, slverr);
      check_bit("pslverr REG_THRESH", 1'b0, slverr);
      check_level("REG_THRESH afull", fifo_pkg::level_t'(AFULL_INIT), rd[4:0]);
      check_level("REG_THRESH aempty", fifo_pkg::level_t'(AEMPTY_INIT), rd[12:8]);
   endtask

   task automatic test_fill_drain();
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
         push_word(next_word());
         check_level_reg();
      end
      for (int i = 0; i < fifo_pkg::DEPTH; i++) begin
         pop_word();
         check_level_reg();
      end
   endtask

   task automatic test_errors();
      for (int i = 0; i < fifo_pkg::DEPTH; i++)
         push_word(next_word());
      refused_request(1'b1);                    // Overflow
      for (int i = 0; i < fifo_pkg::DEPTH; i++)
         pop_word();
      refused_request(1'b0);                    // Underflow
   endtask

   task automatic test_thresholds();
      logic [31:0] rd;
      logic        slverr;
      for (int i = 0; i < 3; i++)
         push_word(next_word());               // Level 3 is still aempty at reset levels
      apb_write(fifo_pkg::REG_THRESH, 32'h0000_0206, slverr);   // aempty 2 and afull 6
      check_bit("pslverr REG_THRESH", 1'b0, slverr);
      thr_afull  = 6;
      thr_aempty = 2;
      @(posedge pos_clk);                       // Flags pick up new levels one edge later
      @(negedge pos_clk);
      check_status("status_o", expected_status(), status);      // aempty drops at level 3
      apb_read(fifo_pkg::REG_THRESH, rd, slverr);
      check_level("REG_THRESH afull", fifo_pkg::level_t'(6), rd[4:0]);
      check_level("REG_THRESH aempty", fifo_pkg::level_t'(2), rd[12:8]);
      for (int i = 3; i < fifo_pkg::DEPTH; i++)
         push_word(next_word());               // Flags checked at each level
      for (int i = 0; i < fifo_pkg::DEPTH; i++)
         pop_word();
   endtask

   task automatic test_push_pop();
      fifo_pkg::data_t d;
      fifo_pkg::data_t exp;
      logic [31:0]     rd;
      logic            slverr;
      for (int i = 0; i < fifo_pkg::DEPTH / 2; i++)
         push_word(next_word());
      for (int i = 0; i < 6; i++) begin
         d = next_word();
         @(posedge pos_clk);
         push  <= 1'b1;
         pop   <= 1'b1;
         wdata <= d;
         @(posedge pos_clk);
         push  <= 1'b0;
         pop   <= 1'b0;
         @(negedge pos_clk);
         check_bit("wack_o", 1'b1, wack);
         check_bit("rvalid_o", 1'b1, rvalid);
         exp = model_q.pop_front();
         check_data("rdata_o", exp, rdata);
         model_q.push_back(d);
         check_status("status_o", expected_status(), status);
         check_level_reg();                     // Level holds at mid point
      end
      while (model_q.size() > 0)
         pop_word();
      apb_read(8'h0C, rd, slverr);
      check_bit("pslverr offset 0x0C", 1'b1, slverr);
      apb_write(fifo_pkg::REG_STATUS, 32'h0, slverr);           // Read-only word
      check_bit("pslverr write REG_STATUS", 1'b1, slverr);
   endtask

   // ----------------------------------------------------------
   // Timeout and main sequence
   // ----------------------------------------------------------
   always @(posedge pos_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         stop_with_failure("Timeout: the tests did not finish within the cycle limit");
   end

   initial begin
      aresetn <= 1'b0;
      push    <= 1'b0;
      pop     <= 1'b0;
      wdata   <= '0;
      apb_req <= '0;
      repeat (2) @(posedge pos_clk);            // Reset held 2 cycles
      aresetn <= 1'b1;
      @(negedge pos_clk);
      test_reset();
      test_fill_drain();
      test_errors();
      test_thresholds();
      test_push_pop();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
hw/fifo_pkg.sv
hw/fifo_ram.sv
hw/fifo_ctrl.sv
hw/fifo_apb_regs.sv
hw/fifo_top.sv
sim/fifo_tb.sv
